// File: Makefile
VERILATOR ?= verilator
TOP ?= GrayFifoTb
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= === PASS ===

SIM := $(OBJDIR)/V$(TOP)
SRCS := $(shell cat files.f)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) files.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f files.f

# fails unless the pass message shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJDIR)

// File: files.f
source/arithPkg.sv
source/fifoPkg.sv
source/IncGray.sv
source/GrayFifoBuffer.sv
source/HandshakeReceiver.sv
source/HandshakeSender.sv
source/GrayFifoTop.sv
tests/GrayFifoTb.sv

// File: source/GrayFifoBuffer.sv
`timescale 1ns/1ps

module GrayFifoBuffer #(
	parameter int dataWidth = fifoPkg::dataWidth,
	parameter int addrWidth = 3,
	parameter arithPkg::prefixArch speed = arithPkg::sklanskyPrefix
) (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 wrEn,
	input  logic [dataWidth-1:0] wrData,
	input  logic                 rdEn,
	output logic [dataWidth-1:0] rdData,
	output fifoPkg::fifoStatus   status
);

	localparam int depth = 2**addrWidth;

	// storage
	logic [dataWidth-1:0] mem [depth];

	// Gray pointers with one extra bit to tell laps apart
	logic [addrWidth:0] wrPtr;
	logic [addrWidth:0] rdPtr;
	logic [addrWidth:0] wrPtrNext;
	logic [addrWidth:0] rdPtrNext;
	// binary array addresses
	logic [addrWidth-1:0] wrBin;
	logic [addrWidth-1:0] rdBin;
	logic doWrite;
	logic doRead;

	// Gray to binary by prefix XOR from the top bit down
	// the lap bit is dropped from the result
	function automatic logic [addrWidth-1:0] grayToBin(input logic [addrWidth:0] g);
		logic [addrWidth:0] b;
		b[addrWidth] = g[addrWidth];
		for (int i = addrWidth - 1; i >= 0; i--) begin
			b[i] = b[i+1] ^ g[i];
		end
		return b[addrWidth-1:0];
	endfunction

	IncGray #(.width(addrWidth + 1), .speed(speed)) wrInc (
		.A(wrPtr),
		.Z(wrPtrNext)
	);

	IncGray #(.width(addrWidth + 1), .speed(speed)) rdInc (
		.A(rdPtr),
		.Z(rdPtrNext)
	);

	assign wrBin = grayToBin(wrPtr);
	assign rdBin = grayToBin(rdPtr);

	// same position and same lap
	assign status.empty = (wrPtr == rdPtr);
	// same position one lap ahead
	// in Gray that flips the two top bits
	assign status.full = (wrPtr == {~rdPtr[addrWidth:addrWidth-1], rdPtr[addrWidth-2:0]});

	// strobes beyond the flags are dropped
	assign doWrite = wrEn & ~status.full;
	assign doRead = rdEn & ~status.empty;

	// head word always on the read port
	assign rdData = mem[rdBin];

	always_ff @(posedge clk) begin
		if (doWrite) begin
			mem[wrBin] <= wrData;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
		end else begin
			if (doWrite) begin
				wrPtr <= wrPtrNext;
			end
			if (doRead) begin
				rdPtr <= rdPtrNext;
			end
		end
	end

endmodule

// File: source/GrayFifoTop.sv
`timescale 1ns/1ps

// handshake in, Gray-pointer FIFO, handshake out
module GrayFifoTop #(
	parameter int dataWidth = fifoPkg::dataWidth,
	parameter int addrWidth = 3,
	parameter arithPkg::prefixArch speed = arithPkg::sklanskyPrefix
) (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 inReq,
	output logic                 inAck,
	input  logic [dataWidth-1:0] inData,
	output logic                 outReq,
	input  logic                 outAck,
	output logic [dataWidth-1:0] outData
);

	// producer to buffer
	logic                 wrEn;
	logic [dataWidth-1:0] wrData;
	// buffer to consumer
	logic                 rdEn;
	logic [dataWidth-1:0] rdData;
	// flags to both sides
	fifoPkg::fifoStatus   status;

	HandshakeReceiver #(.dataWidth(dataWidth)) producer (
		.clk(clk),
		.rstN(rstN),
		.inReq(inReq),
		.inAck(inAck),
		.inData(inData),
		.status(status),
		.wrEn(wrEn),
		.wrData(wrData)
	);

	GrayFifoBuffer #(.dataWidth(dataWidth), .addrWidth(addrWidth), .speed(speed)) buffer (
		.clk(clk),
		.rstN(rstN),
		.wrEn(wrEn),
		.wrData(wrData),
		.rdEn(rdEn),
		.rdData(rdData),
		.status(status)
	);

	HandshakeSender #(.dataWidth(dataWidth)) consumer (
		.clk(clk),
		.rstN(rstN),
		.status(status),
		.rdData(rdData),
		.rdEn(rdEn),
		.outReq(outReq),
		.outAck(outAck),
		.outData(outData)
	);

endmodule

// File: source/HandshakeReceiver.sv
`timescale 1ns/1ps

// four-phase sink on the input side
// one buffer write per transfer
module HandshakeReceiver #(
	parameter int dataWidth = fifoPkg::dataWidth
) (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 inReq,
	output logic                 inAck,
	input  logic [dataWidth-1:0] inData,
	input  fifoPkg::fifoStatus   status,
	output logic                 wrEn,
	output logic [dataWidth-1:0] wrData
);

	fifoPkg::hsState state;

	// write in the cycle the request is seen, if there is room
	// full keeps us in idle with inAck low
	assign wrEn = (state == fifoPkg::idle) && inReq && !status.full;

	// source holds data stable while inReq is high
	assign wrData = inData;

	// ack while waiting for the request to drop
	assign inAck = (state == fifoPkg::holdAck);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= fifoPkg::idle;
		end else begin
			case (state)
				fifoPkg::idle: begin
					if (wrEn) begin
						state <= fifoPkg::holdAck;
					end
				end
				fifoPkg::holdAck: begin
					// request released, drop ack
					if (!inReq) begin
						state <= fifoPkg::idle;
					end
				end
				default: begin
					state <= fifoPkg::idle;
				end
			endcase
		end
	end

endmodule

// File: source/HandshakeSender.sv
`timescale 1ns/1ps

// four-phase source on the output side
// offers the head word, pops it on ack
module HandshakeSender #(
	parameter int dataWidth = fifoPkg::dataWidth
) (
	input  logic                 clk,
	input  logic                 rstN,
	input  fifoPkg::fifoStatus   status,
	input  logic [dataWidth-1:0] rdData,
	output logic                 rdEn,
	output logic                 outReq,
	input  logic                 outAck,
	output logic [dataWidth-1:0] outData
);

	fifoPkg::hsState state;

	// request stays up until the sink answers
	assign outReq = (state == fifoPkg::holdAck);

	// pop in the cycle the ack is seen
	assign rdEn = (state == fifoPkg::holdAck) && outAck;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= fifoPkg::idle;
		end else begin
			case (state)
				fifoPkg::idle: begin
					if (!status.empty) begin
						state <= fifoPkg::holdAck;
					end
				end
				fifoPkg::holdAck: begin
					if (outAck) begin
						state <= fifoPkg::waitRelease;
					end
				end
				fifoPkg::waitRelease: begin
					// sink must drop ack before the next word
					if (!outAck) begin
						state <= fifoPkg::idle;
					end
				end
				default: begin
					state <= fifoPkg::idle;
				end
			endcase
		end
	end

	// capture the head word as the offer starts
	always_ff @(posedge clk) begin
		if (state == fifoPkg::idle && !status.empty) begin
			outData <= rdData;
		end
	end

endmodule

// File: source/IncGray.sv
`timescale 1ns/1ps

// Gray successor without a detour through binary
// parity P picks which bit flips
//   P = 0 -> bit 0 flips
//   P = 1 -> the bit just above the lowest set bit flips
//   the top bit also flips when everything below it is zero
module IncGray #(
	parameter int width = 16,
	parameter arithPkg::prefixArch speed = arithPkg::sklanskyPrefix
) (
	input  logic [width-1:0] A,
	output logic [width-1:0] Z
);

	// prefix inputs and outputs
	logic [width-2:0] PI;
	logic [width-2:0] PO;
	// parity of the operand
	logic parity;
	// candidate flips before and after parity gating
	logic [width-1:1] flipRaw;
	logic [width-1:0] flip;

	RedXor #(.width(width)) parityTree (
		.A(A),
		.Z(parity)
	);

	// a bit is "zero so far" when its operand bit is low
	assign PI[width-2:1] = ~A[width-3:0];

	// serial chain has time to carry the parity along
	if (speed == arithPkg::serialPrefix) begin : genParityIn
		assign PI[0] = parity;
	end else begin : genNoParityIn
		assign PI[0] = 1'b1;
	end

	PrefixAnd #(.width(width-1), .speed(speed)) zeroPrefix (
		.PI(PI),
		.PO(PO)
	);

	// lower bits flip when the bit below is set and all lower bits are zero
	assign flipRaw[width-2:1] = A[width-3:0] & PO[width-3:0];
	// top bit ignores A[width-2]
	assign flipRaw[width-1] = PO[width-2];

	// fast networks apply parity here, after the prefix
	for (genvar i = 1; i < width; i++) begin : genGate
		if (speed == arithPkg::serialPrefix) begin : genPass
			assign flip[i] = flipRaw[i];
		end else begin : genAnd
			assign flip[i] = flipRaw[i] & parity;
		end
	end

	// bit 0 flips on even parity
	assign flip[0] = ~parity;

	assign Z = A ^ flip;

endmodule

// running AND over PI so PO[j] = PI[j] & ... & PI[0]
module PrefixAnd #(
	parameter int width = 8,
	parameter arithPkg::prefixArch speed = arithPkg::sklanskyPrefix
) (
	input  logic [width-1:0] PI,
	output logic [width-1:0] PO
);

	// number of doubling levels
	localparam int depth = $clog2(width);

	if (speed == arithPkg::sklanskyPrefix) begin : genSklansky
		// one row per level with row 0 as the input
		logic [(depth+1)*width-1:0] pt;

		assign pt[width-1:0] = PI;
		for (genvar l = 1; l <= depth; l++) begin : genLevel
			for (genvar k = 0; k < 2**(depth-l); k++) begin : genGroup
				for (genvar i = 0; i < 2**(l-1); i++) begin : genBit
					// lower half of a group keeps its value
					if (k*2**l + i < width) begin : genPass
						assign pt[l*width + k*2**l + i] = pt[(l-1)*width + k*2**l + i];
					end
					// upper half takes the lower half's last prefix
					if (k*2**l + 2**(l-1) + i < width) begin : genNode
						assign pt[l*width + k*2**l + 2**(l-1) + i] =
							pt[(l-1)*width + k*2**l + 2**(l-1) + i] &
							pt[(l-1)*width + k*2**l + 2**(l-1) - 1];
					end
				end
			end
		end
		assign PO = pt[(depth+1)*width-1 -: width];
	end

	if (speed == arithPkg::brentKungPrefix) begin : genBrentKung
		// up-sweep in rows 1..depth and down-sweep in rows depth+1..2*depth-1
		logic [2*depth*width-1:0] pt;

		assign pt[width-1:0] = PI;
		for (genvar l = 1; l <= depth; l++) begin : genUp
			for (genvar j = 0; j < width; j++) begin : genBit
				// node at the top of every aligned block of 2**l
				if ((j+1) % 2**l == 0) begin : genNode
					assign pt[l*width + j] = pt[(l-1)*width + j] &
						pt[(l-1)*width + j - 2**(l-1)];
				end else begin : genPass
					assign pt[l*width + j] = pt[(l-1)*width + j];
				end
			end
		end
		for (genvar l = depth + 1; l < 2*depth; l++) begin : genDown
			for (genvar j = 0; j < width; j++) begin : genBit
				// fill in the middle of each stride from the finished block below
				if (((j+1) % 2**(2*depth-l) == 2**(2*depth-l-1)) &&
						(j >= 2**(2*depth-l))) begin : genNode
					assign pt[l*width + j] = pt[(l-1)*width + j] &
						pt[(l-1)*width + j - 2**(2*depth-l-1)];
				end else begin : genPass
					assign pt[l*width + j] = pt[(l-1)*width + j];
				end
			end
		end
		assign PO = pt[2*depth*width-1 -: width];
	end

	if (speed == arithPkg::serialPrefix) begin : genSerial
		// plain ripple chain
		logic [width-1:0] pt;

		assign pt[0] = PI[0];
		for (genvar i = 1; i < width; i++) begin : genBit
			assign pt[i] = PI[i] & pt[i-1];
		end
		assign PO = pt;
	end

endmodule

// parity of A
module RedXor #(
	parameter int width = 8
) (
	input  logic [width-1:0] A,
	output logic             Z
);

	always_comb begin
		Z = A[0];
		for (int i = 1; i < width; i++) begin
			Z = Z ^ A[i];
		end
	end

endmodule

// File: source/arithPkg.sv
package arithPkg;

	// prefix network used inside the Gray incrementer
	// serial is smallest and deepest
	// Brent-Kung sits in the middle
	// Sklansky is shallowest with the most fan-out
	typedef enum logic [1:0] {
		serialPrefix,
		brentKungPrefix,
		sklanskyPrefix
	} prefixArch;

endpackage

// File: source/fifoPkg.sv
package fifoPkg;

	// default word width
	// the top level overrides it and passes it down
	parameter int dataWidth = 16;

	// handshake phases
	// idle: nothing pending on the port
	// holdAck: one side holds its strobe until the other answers
	// waitRelease: request done, waiting for the other side to drop
	typedef enum logic [1:0] {
		idle,
		holdAck,
		waitRelease
	} hsState;

	// buffer occupancy flags
	// driven by the buffer, read by both handshake ports
	typedef struct packed {
		// no free entry left
		logic full;
		// no word stored
		logic empty;
	} fifoStatus;

endpackage

// File: tests/GrayFifoTb.sv
`timescale 1ns/1ps

module GrayFifoTb;

	localparam int dataWidth = 16;
	localparam int addrWidth = 3;
	localparam int depth = 2**addrWidth;
	// cycles a push may wait before it counts as blocked
	localparam int stallWindow = 12;

	logic clk = 1'b0;
	logic rstN;
	logic inReq;
	logic inAck;
	logic [dataWidth-1:0] inData;
	logic outReq;
	logic outAck;
	logic [dataWidth-1:0] outData;

	// tests as read from the golden file
	string names[$];
	int modes[$];
	int delayMin[$];
	int delayMax[$];
	int firstWord[$];
	int wordCount[$];
	logic [dataWidth-1:0] pushWords[$];
	logic [dataWidth-1:0] expWords[$];

	int errors = 0;
	int failedTests = 0;
	int limitCycles = 0;
	// words through each port in the current test
	int pushed;
	int popped;
	// outReq as seen on the previous falling edge
	logic outReqLast = 1'b0;

	GrayFifoTop #(
		.dataWidth(dataWidth),
		.addrWidth(addrWidth),
		.speed(arithPkg::sklanskyPrefix)
	) dut0 (
		.clk(clk),
		.rstN(rstN),
		.inReq(inReq),
		.inAck(inAck),
		.inData(inData),
		.outReq(outReq),
		.outAck(outAck),
		.outData(outData)
	);

	// 100 ns period
	always #50 clk = ~clk;

	// every rise of outReq is one word offered at the output
	always @(negedge clk) begin
		if (outReq && !outReqLast) begin
			popped++;
		end
		outReqLast = outReq;
	end

	task automatic readTests(input int fd);
		string line;
		string name;
		int mode;
		int dMin;
		int dMax;
		int cnt;
		int total;
		logic [dataWidth-1:0] w;
		total = 200;
		// two comment lines name the columns
		void'($fgets(line, fd));
		void'($fgets(line, fd));
		while ($fscanf(fd, " test %s %d %d %d %d", name, mode, dMin, dMax, cnt) == 5) begin
			names.push_back(name);
			modes.push_back(mode);
			delayMin.push_back(dMin);
			delayMax.push_back(dMax);
			firstWord.push_back(pushWords.size());
			wordCount.push_back(cnt);
			for (int i = 0; i < cnt; i++) begin
				void'($fscanf(fd, "%h", w));
				pushWords.push_back(w);
			end
			for (int i = 0; i < cnt; i++) begin
				void'($fscanf(fd, "%h", w));
				expWords.push_back(w);
			end
			// worst handshake per word doubled as margin
			total += cnt * (16 + dMax + stallWindow) * 2;
		end
		$fclose(fd);
		limitCycles = total;
	endtask

	// raise inReq with w and give up after limit cycles (0 waits forever)
	task automatic offerWord(input logic [dataWidth-1:0] w, input int limit,
			output bit accepted);
		int waited;
		waited = 0;
		inData = w;
		inReq = 1'b1;
		do begin
			@(negedge clk);
			waited++;
		end while (!inAck && (limit == 0 || waited < limit));
		accepted = inAck;
	endtask

	// second half of the input handshake
	task automatic releaseWord();
		inReq = 1'b0;
		do begin
			@(negedge clk);
		end while (inAck);
	endtask

	task automatic sendWords(input int t, input int from);
		bit accepted;
		for (int i = from; i < wordCount[t]; i++) begin
			offerWord(pushWords[firstWord[t] + i], 0, accepted);
			releaseWord();
			pushed++;
		end
	endtask

	// sink side with a random outAck delay per word
	task automatic takeWords(input int t);
		int delay;
		logic [dataWidth-1:0] expected;
		for (int i = 0; i < wordCount[t]; i++) begin
			while (!outReq) begin
				@(negedge clk);
			end
			expected = expWords[firstWord[t] + i];
			assert (outData == expected) else begin
				$display("ERROR %s: word %0d expected %h actual %h",
					names[t], i, expected, outData);
				errors++;
			end
			delay = delayMin[t] + int'($urandom % (delayMax[t] - delayMin[t] + 1));
			repeat (delay) @(negedge clk);
			outAck = 1'b1;
			do begin
				@(negedge clk);
			end while (outReq);
			outAck = 1'b0;
		end
	endtask

	function automatic void reportTest(input string name, input int errorsBefore);
		if (errors == errorsBefore) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: failed with %0d errors", name, errors - errorsBefore);
			failedTests++;
		end
	endfunction

	// nothing pushed yet so both ports stay quiet
	task automatic checkReset();
		int errorsBefore;
		errorsBefore = errors;
		assert (!inAck && !outReq) else begin
			$display("ERROR reset: expected inAck 0 outReq 0 actual inAck %b outReq %b",
				inAck, outReq);
			errors++;
		end
		repeat (10) begin
			@(negedge clk);
			assert (!outReq) else begin
				$display("reset: outReq rose although nothing was pushed");
				errors++;
			end
		end
		reportTest("reset", errorsBefore);
	endtask

	task automatic runTest(input int t);
		int errorsBefore;
		int completed;
		bit accepted;
		errorsBefore = errors;
		pushed = 0;
		popped = 0;
		if (modes[t] == 1) begin
			// sink stalled while pushes fill the buffer
			completed = 0;
			accepted = 1'b1;
			while (accepted && completed < wordCount[t]) begin
				offerWord(pushWords[firstWord[t] + completed], stallWindow, accepted);
				if (accepted) begin
					releaseWord();
					completed++;
				end
			end
			assert (completed == depth) else begin
				$display("ERROR %s: pushes before stall expected %0d actual %0d",
					names[t], depth, completed);
				errors++;
			end
			pushed = completed;
			fork
				begin
					// blocked word keeps inReq high until an entry frees up
					if (!accepted) begin
						while (!inAck) begin
							@(negedge clk);
						end
						releaseWord();
						pushed++;
					end
					sendWords(t, pushed);
				end
				takeWords(t);
			join
		end else begin
			fork
				sendWords(t, 0);
				takeWords(t);
			join
		end
		repeat (4) @(negedge clk);
		assert (popped == pushed) else begin
			$display("ERROR %s: word count expected %0d actual %0d",
				names[t], pushed, popped);
			errors++;
		end
		assert (!outReq) else begin
			$display("%s: an extra word was offered after the last one", names[t]);
			errors++;
		end
		reportTest(names[t], errorsBefore);
	endtask

	initial begin
		int fd;
		rstN = 1'b0;
		inReq = 1'b0;
		inData = '0;
		outAck = 1'b0;
		void'($urandom(32'hdea1));
		fd = $fopen("tests/golden_fifo_vectors.txt", "r");
		repeat (16) @(negedge clk);
		rstN = 1'b1;
		@(negedge clk);
		if (fd == 0) begin
			$display("cannot open tests/golden_fifo_vectors.txt");
			errors++;
		end else begin
			readTests(fd);
			checkReset();
			for (int t = 0; t < names.size(); t++) begin
				runTest(t);
			end
		end
		$display("%0d tests, %0d failed, %0d errors", names.size() + 1, failedTests, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// limit comes from the word counts in the golden file
	initial begin
		wait (limitCycles > 0);
		repeat (limitCycles) @(posedge clk);
		$display("timeout after %0d cycles, a handshake never completed", limitCycles);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: tests/golden_fifo_vectors.txt
# test <name> <mode 0 free sink, 1 sink stalled until full> <delay min> <delay max> <words>
# then the pushed words in hex, then the expected output words in hex
test single 0 0 0 1
a5c3
a5c3
test wrap20 0 0 0 20
0001 0002 0004 0008 0010 0020 0040 0080 0100 0200
0400 0800 1000 2000 4000 8000 ffff 0000 5555 aaaa
0001 0002 0004 0008 0010 0020 0040 0080 0100 0200
0400 0800 1000 2000 4000 8000 ffff 0000 5555 aaaa
test full9 1 0 0 9
1111 2222 3333 4444 5555 6666 7777 8888 9999
1111 2222 3333 4444 5555 6666 7777 8888 9999
test randomSink 0 0 7 12
3c5a 9e01 0f0f f0f0 1234 5678 9abc def0 beef cafe 7e7e 0180
3c5a 9e01 0f0f f0f0 1234 5678 9abc def0 beef cafe 7e7e 0180
